// ==== hdl/vid_geom_pkg.sv ====
//##########################################################
// video geometry types shared by the timers and the monitor
// counts are 12 bit, as on the retro chipset timing
// guard values assume lines well over 16 pixels long
//##########################################################
`default_nettype none

package vid_geom_pkg;

	typedef logic [11:0] coord_t; // pixel or line count

	localparam int H_GUARD     = 8; // columns blanked at each line end
	localparam int V_GUARD_TOP = 1; // first line allowed on screen
	localparam int V_GUARD_BOT = 3; // lines blanked before frame end

	localparam int FLAG_W = 7; // mode change counter width

	// one sample per frame, taken at vblank end
	typedef struct packed {
		coord_t     hsize;
		coord_t     vsize;
		logic [1:0] res;
	} mode_sample_t;

endpackage

`default_nettype wire

// ==== hdl/crop_ctrl_pkg.sv ====
//##########################################################
// keyboard codes and host register map for the crop control
// register indices are word addresses (byte address / 4)
//##########################################################
`default_nettype none

package crop_ctrl_pkg;

	localparam int KMS_KEY_TYPE = 3; // kbd_type of a key event

	localparam logic [7:0] KEY_BKSP     = 8'h41;
	localparam logic [7:0] KEY_UP       = 8'h4c;
	localparam logic [7:0] KEY_DOWN     = 8'h4d;
	localparam logic [7:0] KEY_RIGHT    = 8'h4e;
	localparam logic [7:0] KEY_LEFT     = 8'h4f;
	localparam logic [7:0] KEY_ALT_L_DN = 8'h64;
	localparam logic [7:0] KEY_ALT_R_DN = 8'h65;
	localparam logic [7:0] KEY_ALT_L_UP = 8'he4;
	localparam logic [7:0] KEY_ALT_R_UP = 8'he5;

	localparam int V_STEP = 1; // lines per key press
	localparam int H_STEP = 4; // pixels per key press

	localparam int APB_DW = 32;

	localparam int REG_MARGIN_H = 0; // left 11..0, right 27..16
	localparam int REG_MARGIN_V = 1; // top 11..0, bottom 27..16
	localparam int REG_LOAD     = 2; // write only
	localparam int REG_SIZE     = 3; // read only
	localparam int REG_STATUS   = 4; // read only

endpackage

`default_nettype wire

// ==== hdl/crop_margin_if.sv ====
//##########################################################
// the four software blanking margins as one bundle
// all signals live in the clk_sys domain
//##########################################################
`default_nettype none
`timescale 1ns/10ps

interface crop_margin_if #(
	parameter int COORD_W = $bits(vid_geom_pkg::coord_t)
);

	logic [COORD_W-1:0] hbl_l; // left, pixels
	logic [COORD_W-1:0] hbl_r; // right, pixels
	logic [COORD_W-1:0] vbl_t; // top, lines
	logic [COORD_W-1:0] vbl_b; // bottom, lines

	modport source (output hbl_l, hbl_r, vbl_t, vbl_b);
	modport sink   (input  hbl_l, hbl_r, vbl_t, vbl_b);

endinterface

`default_nettype wire

// ==== hdl/line_timer.sv ====
//##########################################################
// horizontal measurement and crop
// hs is active low; counting restarts at the end of hsync
// margins compare against edges of the previous line
//##########################################################
`default_nettype none
`timescale 1ns/10ps

module line_timer #(
	parameter int COORD_W = 12
) (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  hs,
	input  wire                  hblank,
	input  wire                  sample_line,
	crop_margin_if.sink          margin,
	output logic                 hbl,
	output vid_geom_pkg::coord_t hsize
);

	localparam logic [COORD_W-1:0] GUARD = COORD_W'(vid_geom_pkg::H_GUARD);
	localparam logic [COORD_W-1:0] LAT   = COORD_W'(2); // edge capture latency

	logic [COORD_W-1:0] hcnt, hend, hsta, hmax;
	logic old_hs, old_hblank;
	logic shbl, fhbl;
	logic synced; // a full line has been counted
	logic hb_fall, hb_rise, hs_fall;

	assign hb_fall = old_hblank & ~hblank;
	assign hb_rise = ~old_hblank & hblank;
	assign hs_fall = old_hs & ~hs;

	assign hbl = shbl | fhbl | ~hs;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_hs     <= 1'b1;
			old_hblank <= 1'b0;
			hcnt       <= '0;
			hend       <= '0;
			hsta       <= '0;
			hmax       <= '0;
			shbl       <= 1'b1;
			fhbl       <= 1'b1;
			synced     <= 1'b0;
			hsize      <= '0;
		end else begin
			old_hs     <= hs;
			old_hblank <= hblank;

			if (~hs) hcnt <= '0;
			else     hcnt <= hcnt + 1'b1;
			if (~old_hs & hs) synced <= 1'b1;

			if (hb_fall) hend <= hcnt;
			if (hb_rise) hsta <= hcnt;
			if (hs_fall) hmax <= hcnt;

			if (hcnt == hend + margin.hbl_l - LAT) shbl <= 1'b0;
			if (hcnt == hsta + margin.hbl_r - LAT) shbl <= 1'b1;

			if (hcnt == GUARD)        fhbl <= 1'b0; // guard columns on both ends
			if (hcnt == hmax - GUARD) fhbl <= 1'b1;

			if (hb_rise & sample_line) hsize <= vid_geom_pkg::coord_t'(hcnt - hend);
		end
	end

	// a measured line must leave room for both guard bands
	assert property (@(posedge clk_sys) disable iff (reset)
		hs_fall && synced |=> hmax >= COORD_W'(2 * vid_geom_pkg::H_GUARD));

endmodule

`default_nettype wire

// ==== hdl/frame_timer.sv ====
//##########################################################
// vertical measurement and crop, and the final hde/vde
// hs and vs active low; interlace needs field1 from source
// vertical flags only move at the start of a visible line
//##########################################################
`default_nettype none
`timescale 1ns/10ps

module frame_timer #(
	parameter int COORD_W = 12
) (
	input  wire                  clk_sys,
	input  wire                  reset,
	input  wire                  hs,
	input  wire                  vs,
	input  wire                  vblank,
	input  wire                  field1,
	input  wire                  hbl,
	crop_margin_if.sink          margin,
	output logic                 sample_line,
	output vid_geom_pkg::coord_t vsize,
	output logic                 vblank_end,
	output logic                 hde,
	output logic                 vde
);

	localparam logic [COORD_W-1:0] ONE     = COORD_W'(1);
	localparam logic [COORD_W-1:0] G_TOP   = COORD_W'(vid_geom_pkg::V_GUARD_TOP);
	localparam logic [COORD_W-1:0] G_BOT   = COORD_W'(vid_geom_pkg::V_GUARD_BOT);

	logic [COORD_W-1:0] vcnt, vend, vsta, vmax;
	logic [COORD_W-1:0] f1_vend, f1_vsize; // odd field
	logic old_vs, old_hs, old_vbl, old_hbl;
	logic svbl, fvbl;
	logic vbl_eff, vb_fall, vb_rise;

	assign vbl_eff = vblank | ~vs;
	assign vb_fall = old_vbl & ~vbl_eff;
	assign vb_rise = ~old_vbl & vbl_eff;

	assign vblank_end  = vb_fall;
	assign sample_line = ~field1 & (vcnt == vsta + ONE);
	assign vde         = ~(fvbl | svbl);

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			old_vs   <= 1'b1;
			old_hs   <= 1'b1;
			old_vbl  <= 1'b1;
			old_hbl  <= 1'b1;
			vcnt     <= '0;
			vend     <= '0;
			vsta     <= '0;
			vmax     <= '0;
			f1_vend  <= '0;
			f1_vsize <= '0;
			vsize    <= '0;
			svbl     <= 1'b1;
			fvbl     <= 1'b1;
			hde      <= 1'b0;
		end else begin
			old_vs  <= vs;
			old_hs  <= hs;
			old_vbl <= vbl_eff;
			old_hbl <= hbl;

			if (~vs)               vcnt <= '0;
			else if (old_hs & ~hs) vcnt <= vcnt + 1'b1;

			if (~field1) begin
				if (vb_fall)      vend <= vcnt;
				if (vb_rise)      vsta <= vcnt;
				if (old_vs & ~vs) vmax <= vcnt;
				if (vb_rise) begin
					vsize    <= vid_geom_pkg::coord_t'(vcnt - vend + f1_vsize); // both fields
					f1_vsize <= '0;
				end
			end else begin
				if (vb_fall) f1_vend <= vcnt;
				if (vb_rise) f1_vsize <= vcnt - f1_vend;
			end

			if (old_hbl & ~hbl) begin
				if (vcnt == vend + margin.vbl_t - ONE) svbl <= 1'b0;
				if (vcnt == vsta + margin.vbl_b - ONE) svbl <= 1'b1;
				if (vcnt == G_TOP)                     fvbl <= 1'b0;
				if (vcnt == vmax - G_BOT)              fvbl <= 1'b1;
			end

			hde <= ~hbl; // one cycle behind hbl
		end
	end

endmodule

`default_nettype wire

// ==== hdl/crop_keys.sv ====
//##########################################################
// live margin registers, stepped from keyboard events
// keyboard inputs are sampled once before decoding
// a host load overrides a key event in the same cycle
//##########################################################
`default_nettype none
`timescale 1ns/10ps

module crop_keys #(
	parameter int COORD_W = 12
) (
	input  wire       clk_sys,
	input  wire       reset,
	input  wire       kms_level,
	input  wire [1:0] kbd_type,
	input  wire [7:0] kbd_data,
	input  wire       load,
	crop_margin_if.sink   preset,
	crop_margin_if.source margin
);

	localparam logic [COORD_W-1:0] VSTEP = COORD_W'(crop_ctrl_pkg::V_STEP);
	localparam logic [COORD_W-1:0] HSTEP = COORD_W'(crop_ctrl_pkg::H_STEP);

	logic       lvl_q, lvl_qq, alt;
	logic [1:0] type_q;
	logic [7:0] data_q;
	logic       key_ev;

	assign key_ev = (lvl_q ^ lvl_qq) && (type_q == 2'(crop_ctrl_pkg::KMS_KEY_TYPE));

	always_ff @(posedge clk_sys) begin
		type_q <= kbd_type;
		data_q <= kbd_data;
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			lvl_q        <= 1'b0;
			lvl_qq       <= 1'b0;
			alt          <= 1'b0;
			margin.hbl_l <= '0;
			margin.hbl_r <= '0;
			margin.vbl_t <= '0;
			margin.vbl_b <= '0;
		end else begin
			lvl_q  <= kms_level;
			lvl_qq <= lvl_q;
			if (key_ev) begin
				case (data_q)
					crop_ctrl_pkg::KEY_BKSP: begin
						margin.hbl_l <= '0;
						margin.hbl_r <= '0;
						margin.vbl_t <= '0;
						margin.vbl_b <= '0;
					end
					crop_ctrl_pkg::KEY_UP:
						if (alt) margin.vbl_b <= margin.vbl_b + VSTEP;
						else     margin.vbl_t <= margin.vbl_t + VSTEP;
					crop_ctrl_pkg::KEY_DOWN:
						if (alt) margin.vbl_b <= margin.vbl_b - VSTEP;
						else     margin.vbl_t <= margin.vbl_t - VSTEP;
					crop_ctrl_pkg::KEY_LEFT:
						if (alt) margin.hbl_r <= margin.hbl_r + HSTEP;
						else     margin.hbl_l <= margin.hbl_l + HSTEP;
					crop_ctrl_pkg::KEY_RIGHT:
						if (alt) margin.hbl_r <= margin.hbl_r - HSTEP;
						else     margin.hbl_l <= margin.hbl_l - HSTEP;
					crop_ctrl_pkg::KEY_ALT_L_DN, crop_ctrl_pkg::KEY_ALT_R_DN: alt <= 1'b1;
					crop_ctrl_pkg::KEY_ALT_L_UP, crop_ctrl_pkg::KEY_ALT_R_UP: alt <= 1'b0;
					default: ; // other keys ignored
				endcase
			end
			if (load) begin
				margin.hbl_l <= preset.hbl_l;
				margin.hbl_r <= preset.hbl_r;
				margin.vbl_t <= preset.vbl_t;
				margin.vbl_b <= preset.vbl_b;
			end
		end
	end

	// the host port issues load as a single pulse per write
	assert property (@(posedge clk_sys) disable iff (reset) load |=> !load);

endmodule

`default_nettype wire

// ==== hdl/mode_monitor.sv ====
//##########################################################
// per frame snapshot of active size and resolution
// the change counter wraps; the host compares two reads
//##########################################################
`default_nettype none
`timescale 1ns/10ps

module mode_monitor (
	input  wire                                  clk_sys,
	input  wire                                  reset,
	input  wire                                  vblank_end,
	input  wire vid_geom_pkg::coord_t            hsize,
	input  wire vid_geom_pkg::coord_t            vsize,
	input  wire [1:0]                            res,
	output vid_geom_pkg::mode_sample_t           sample,
	output logic [vid_geom_pkg::FLAG_W-1:0]      change_cnt
);

	vid_geom_pkg::mode_sample_t cur;

	assign cur.hsize = hsize;
	assign cur.vsize = vsize;
	assign cur.res   = res;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			sample     <= '0;
			change_cnt <= '0;
		end else if (vblank_end) begin
			sample <= cur;
			if (cur != sample) change_cnt <= change_cnt + 1'b1; // any field differs
		end
	end

endmodule

`default_nettype wire

// ==== hdl/crop_apb.sv ====
//##########################################################
// APB slave for preset margins, load and the mode snapshot
// pready is tied high; unaligned or unmapped access errors
// margin reads return the live values, not the presets
//##########################################################
`default_nettype none
`timescale 1ns/10ps

module crop_apb (
	input  wire                                   clk_sys,
	input  wire                                   reset,
	input  wire [4:0]                             paddr,
	input  wire                                   psel,
	input  wire                                   penable,
	input  wire                                   pwrite,
	input  wire [crop_ctrl_pkg::APB_DW-1:0]       pwdata,
	output logic [crop_ctrl_pkg::APB_DW-1:0]      prdata,
	output logic                                  pready,
	output logic                                  pslverr,
	crop_margin_if.source                         preset,
	crop_margin_if.sink                           live,
	output logic                                  load,
	input  wire vid_geom_pkg::mode_sample_t       sample,
	input  wire [vid_geom_pkg::FLAG_W-1:0]        change_cnt
);

	logic [2:0] word;
	logic access, mapped, rd_only, err, wr_en;

	assign word    = paddr[4:2];
	assign access  = psel & penable;
	assign mapped  = (paddr[1:0] == 2'b00) && (word <= 3'(crop_ctrl_pkg::REG_STATUS));
	assign rd_only = (word == 3'(crop_ctrl_pkg::REG_SIZE)) ||
	                 (word == 3'(crop_ctrl_pkg::REG_STATUS));
	assign err     = ~mapped | (pwrite & rd_only);
	assign wr_en   = access & pwrite & ~err;

	assign pready  = 1'b1; // no wait states
	assign pslverr = access & err;

	always_comb begin
		prdata = '0;
		case (word)
			3'(crop_ctrl_pkg::REG_MARGIN_H): begin
				prdata[11:0]  = vid_geom_pkg::coord_t'(live.hbl_l);
				prdata[27:16] = vid_geom_pkg::coord_t'(live.hbl_r);
			end
			3'(crop_ctrl_pkg::REG_MARGIN_V): begin
				prdata[11:0]  = vid_geom_pkg::coord_t'(live.vbl_t);
				prdata[27:16] = vid_geom_pkg::coord_t'(live.vbl_b);
			end
			3'(crop_ctrl_pkg::REG_SIZE): begin
				prdata[11:0]  = sample.hsize;
				prdata[27:16] = sample.vsize;
			end
			3'(crop_ctrl_pkg::REG_STATUS): begin
				prdata[1:0]                     = sample.res;
				prdata[8 +: vid_geom_pkg::FLAG_W] = change_cnt;
			end
			default: ; // load reads as zero
		endcase
	end

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			preset.hbl_l <= '0;
			preset.hbl_r <= '0;
			preset.vbl_t <= '0;
			preset.vbl_b <= '0;
			load         <= 1'b0;
		end else begin
			load <= wr_en && (word == 3'(crop_ctrl_pkg::REG_LOAD));
			if (wr_en && (word == 3'(crop_ctrl_pkg::REG_MARGIN_H))) begin
				preset.hbl_l <= pwdata[11:0];
				preset.hbl_r <= pwdata[27:16];
			end
			if (wr_en && (word == 3'(crop_ctrl_pkg::REG_MARGIN_V))) begin
				preset.vbl_t <= pwdata[11:0];
				preset.vbl_b <= pwdata[27:16];
			end
		end
	end

	// access phase only ever follows a selected setup phase
	assert property (@(posedge clk_sys) disable iff (reset) penable |-> psel);

endmodule

`default_nettype wire

// ==== hdl/video_crop_top.sv ====
//##########################################################
// display crop for retro sync/blank video, single clock
// hs and vs active low; hde/vde active high
// host access over APB, keyboard via level-toggle events
//##########################################################
`default_nettype none
`timescale 1ns/10ps

module video_crop_top #(
	parameter int COORD_W = 12
) (
	input  wire                              clk_sys,
	input  wire                              reset,
	input  wire                              hs,
	input  wire                              vs,
	input  wire                              hblank,
	input  wire                              vblank,
	input  wire                              field1,
	input  wire [1:0]                        res,
	input  wire                              kms_level,
	input  wire [1:0]                        kbd_type,
	input  wire [7:0]                        kbd_data,
	input  wire [4:0]                        paddr,
	input  wire                              psel,
	input  wire                              penable,
	input  wire                              pwrite,
	input  wire [crop_ctrl_pkg::APB_DW-1:0]  pwdata,
	output wire [crop_ctrl_pkg::APB_DW-1:0]  prdata,
	output wire                              pready,
	output wire                              pslverr,
	output wire                              hde,
	output wire                              vde
);

	wire                                hbl;
	wire                                sample_line;
	wire                                vblank_end;
	wire                                load;
	wire vid_geom_pkg::coord_t          hsize;
	wire vid_geom_pkg::coord_t          vsize;
	wire vid_geom_pkg::mode_sample_t    sample;
	wire [vid_geom_pkg::FLAG_W-1:0]     change_cnt;

	crop_margin_if #(.COORD_W(COORD_W)) live ();   // margins in use
	crop_margin_if #(.COORD_W(COORD_W)) preset (); // host staging

	line_timer #(.COORD_W(COORD_W)) u_line (
		.clk_sys(clk_sys), .reset(reset), .hs(hs), .hblank(hblank),
		.sample_line(sample_line), .margin(live.sink), .hbl(hbl), .hsize(hsize)
	);

	frame_timer #(.COORD_W(COORD_W)) u_frame (
		.clk_sys(clk_sys), .reset(reset), .hs(hs), .vs(vs), .vblank(vblank),
		.field1(field1), .hbl(hbl), .margin(live.sink), .sample_line(sample_line),
		.vsize(vsize), .vblank_end(vblank_end), .hde(hde), .vde(vde)
	);

	crop_keys #(.COORD_W(COORD_W)) u_keys (
		.clk_sys(clk_sys), .reset(reset), .kms_level(kms_level), .kbd_type(kbd_type),
		.kbd_data(kbd_data), .load(load), .preset(preset.sink), .margin(live.source)
	);

	mode_monitor u_mon (
		.clk_sys(clk_sys), .reset(reset), .vblank_end(vblank_end), .hsize(hsize),
		.vsize(vsize), .res(res), .sample(sample), .change_cnt(change_cnt)
	);

	crop_apb u_apb (
		.clk_sys(clk_sys), .reset(reset), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .preset(preset.source), .live(live.sink),
		.load(load), .sample(sample), .change_cnt(change_cnt)
	);

endmodule

`default_nettype wire

// ==== bench/video_crop_tb.sv ====
//##########################################################
// data driven testbench for the display crop top level
// records come from bench/crop_input.txt, run from the root
// frames are progressive only and field1 stays low
//##########################################################
`default_nettype none
`timescale 1ns/10ps

module video_crop_tb;

	logic        clk_sys, reset;
	logic        hs, vs, hblank, vblank, field1;
	logic [1:0]  res, kbd_type;
	logic        kms_level;
	logic [7:0]  kbd_data;
	logic [4:0]  paddr;
	logic        psel, penable, pwrite;
	logic [31:0] pwdata;
	wire  [31:0] prdata;
	wire         pready, pslverr, hde, vde;

	int     rec_v[9];  // fields of the current record
	byte    rec_kind;
	int     pass_cnt, err_cnt;
	longint cycles, limit;

	video_crop_top #(.COORD_W(12)) UUT (
		.clk_sys(clk_sys), .reset(reset), .hs(hs), .vs(vs), .hblank(hblank),
		.vblank(vblank), .field1(field1), .res(res), .kms_level(kms_level),
		.kbd_type(kbd_type), .kbd_data(kbd_data), .paddr(paddr), .psel(psel),
		.penable(penable), .pwrite(pwrite), .pwdata(pwdata), .prdata(prdata),
		.pready(pready), .pslverr(pslverr), .hde(hde), .vde(vde)
	);

	initial begin
		clk_sys = 1'b0;
		forever #4 clk_sys = ~clk_sys; // 8 ns period
	end

	always @(posedge clk_sys) begin
		cycles++;
		if (limit != 0 && cycles > limit) begin
			$display("timeout: run went past %0d cycles without finishing", limit);
			$display("SOME TESTS FAILED");
			$finish;
		end
	end

	// skips comment lines and returns kind 0 at end of file
	task automatic next_record(input int fd);
		string skip;
		int    n;
		rec_kind = 0;
		forever begin
			n = $fscanf(fd, " %c", rec_kind);
			if (n != 1) begin
				rec_kind = 0;
				return;
			end
			if (rec_kind != "#") break;
			n = $fgets(skip, fd);
		end
		case (rec_kind)
			"K": n = $fscanf(fd, "%h", rec_v[0]);
			"W", "R": n = $fscanf(fd, "%h %h %d", rec_v[0], rec_v[1], rec_v[2]);
			"F": n = $fscanf(fd, "%d %d %d %d %d %d %d %d %d", rec_v[0], rec_v[1],
				rec_v[2], rec_v[3], rec_v[4], rec_v[5], rec_v[6], rec_v[7], rec_v[8]);
			default: n = 0;
		endcase
	endtask

	task automatic send_key(input logic [7:0] code);
		@(posedge clk_sys);
		kbd_type  <= 2'd3;
		kbd_data  <= code;
		kms_level <= ~kms_level; // one toggle per event
		repeat (4) @(posedge clk_sys);
	endtask

	task automatic apb_xfer(input logic wr, input logic [4:0] addr, input logic [31:0] wdata,
		output logic [31:0] rdata, output logic err);
		@(posedge clk_sys);
		paddr   <= addr;
		pwrite  <= wr;
		pwdata  <= wdata;
		psel    <= 1'b1;
		penable <= 1'b0;
		@(posedge clk_sys);
		penable <= 1'b1;
		@(posedge clk_sys);
		rdata = prdata; // still the access cycle value
		err   = pslverr;
		assert (pready === 1'b1) else begin
			err_cnt++;
			$display("ERR %0t: pready low in the access cycle", $time);
		end
		psel    <= 1'b0;
		penable <= 1'b0;
	endtask

	// progressive frame with vs low on line 0 and hde counted on one line
	task automatic run_frame(input int len, hbf, hbr, hsw, lines, vbe, vbs, r,
		output int hde_cnt);
		int mid;
		mid = (vbe + vbs) / 2;
		hde_cnt = 0;
		for (int y = 0; y < lines; y++) begin
			for (int c = 0; c < len; c++) begin
				@(posedge clk_sys);
				if (y == mid && hde) hde_cnt++;
				hs     <= (c >= hsw);
				hblank <= (c < hbf) || (c >= hbr);
				vs     <= (y != 0);
				vblank <= (y < vbe) || (y >= vbs);
				res    <= 2'(r);
			end
		end
		@(posedge clk_sys);
		hs     <= 1'b1; // idle between records
		hblank <= 1'b1;
		vs     <= 1'b1;
		vblank <= 1'b1;
	endtask

	task automatic check_val(input int rec, input string what, input longint got, exp);
		assert (got == exp) begin
			pass_cnt++;
			$display("rec %0d %s ok", rec, what);
		end else begin
			err_cnt++;
			$display("ERR %0t: rec %0d %s got %0h expected %0h", $time, rec, what, got, exp);
		end
	endtask

	initial begin
		int          fd, rec, hcnt;
		logic [31:0] rdata;
		logic        err;
		reset = 1'b1;
		hs = 1'b1;
		vs = 1'b1;
		hblank = 1'b1;
		vblank = 1'b1;
		field1 = 1'b0;
		res = 2'd0;
		kms_level = 1'b0;
		kbd_type = 2'd0;
		kbd_data = 8'd0;
		paddr = 5'd0;
		psel = 1'b0;
		penable = 1'b0;
		pwrite = 1'b0;
		pwdata = 32'd0;
		pass_cnt = 0;
		err_cnt = 0;
		cycles = 0;
		limit = 0;
		fd = $fopen("bench/crop_input.txt", "r");
		if (fd == 0) begin
			$display("could not open bench/crop_input.txt");
			$display("SOME TESTS FAILED");
			$finish;
		end
		// first pass sizes the run
		forever begin
			next_record(fd);
			if (rec_kind == 0) break;
			if (rec_kind == "F") limit += rec_v[0] * rec_v[4];
			else limit += 20;
		end
		limit = 2 * (limit + 20);
		$fclose(fd);
		fd = $fopen("bench/crop_input.txt", "r");
		repeat (10) @(posedge clk_sys);
		reset <= 1'b0;
		repeat (2) @(posedge clk_sys);
		check_val(0, "hde after reset", hde, 0);
		check_val(0, "vde after reset", vde, 0);
		check_val(0, "pslverr after reset", pslverr, 0);
		rec = 0;
		forever begin
			next_record(fd);
			if (rec_kind == 0) break;
			rec++;
			case (rec_kind)
				"K": begin
					send_key(8'(rec_v[0]));
					$display("rec %0d key %02h sent", rec, rec_v[0]);
				end
				"W": begin
					apb_xfer(1'b1, 5'(rec_v[0]), 32'(rec_v[1]), rdata, err);
					check_val(rec, "write pslverr", err, rec_v[2]);
				end
				"R": begin
					apb_xfer(1'b0, 5'(rec_v[0]), 32'd0, rdata, err);
					check_val(rec, "read data", rdata, 32'(rec_v[1]));
					check_val(rec, "read pslverr", err, rec_v[2]);
				end
				"F": begin
					run_frame(rec_v[0], rec_v[1], rec_v[2], rec_v[3], rec_v[4], rec_v[5],
						rec_v[6], rec_v[7], hcnt);
					check_val(rec, "hde count", hcnt, rec_v[8]);
				end
				default: begin
					err_cnt++;
					$display("rec %0d has an unknown record type", rec);
				end
			endcase
		end
		$fclose(fd);
		$display("checks: %0d passed, %0d failed", pass_cnt, err_cnt);
		if (err_cnt == 0) begin
			$display("ALL TESTS PASSED");
		end else begin
			$display("SOME TESTS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== build.f ====
hdl/vid_geom_pkg.sv
hdl/crop_ctrl_pkg.sv
hdl/crop_margin_if.sv
hdl/line_timer.sv
hdl/frame_timer.sv
hdl/crop_keys.sv
hdl/mode_monitor.sv
hdl/crop_apb.sv
hdl/video_crop_top.sv
bench/video_crop_tb.sv

// ==== Bender.yml ====
package:
  name: video_crop

sources:
  - hdl/vid_geom_pkg.sv
  - hdl/crop_ctrl_pkg.sv
  - hdl/crop_margin_if.sv
  - hdl/line_timer.sv
  - hdl/frame_timer.sv
  - hdl/crop_keys.sv
  - hdl/mode_monitor.sv
  - hdl/crop_apb.sv
  - hdl/video_crop_top.sv
  - target: test
    files:
      - bench/video_crop_tb.sv

// ==== bench/crop_input.txt ====
# K code | W byte_addr data pslverr | R byte_addr expected_data pslverr (hex, err 0/1)
# F len hbl_fall hbl_rise hsync_w lines vbl_end vbl_start res hde_count (decimal)
R 00 00000000 0
R 04 00000000 0
R 0C 00000000 0
R 10 00000000 0
R 07 00000000 1
R 1C 00000000 1
W 0C 12345678 1
W 00 00100004 0
W 04 00030002 0
R 00 00000000 0
W 08 00000000 0
R 00 00100004 0
R 04 00030002 0
K 41
R 00 00000000 0
R 04 00000000 0
K 4C
K 4C
K 64
K 4C
K 4F
R 04 00010002 0
K E4
K 4F
K 4E
K 4E
K 4D
K 4D
K 4D
R 00 00040FFC 0
R 04 00010FFF 0
K 65
K 4E
K E5
R 00 00000FFC 0
W 00 00000008 0
W 04 00000000 0
W 08 00000000 0
R 00 00000008 0
F 100 20 84 6 40 10 34 1 56
F 100 20 84 6 40 10 34 1 56
F 100 20 84 6 40 10 34 1 56
R 0C 00180040 0
R 10 00000201 0
F 100 20 84 6 40 10 34 2 56
R 10 00000302 0
F 100 20 84 6 40 10 34 2 56
R 10 00000302 0
F 100 20 84 6 40 10 30 2 56
R 10 00000302 0
F 100 20 84 6 40 10 30 2 56
F 100 20 84 6 40 10 30 2 56
R 0C 00140040 0
R 10 00000402 0
